//--- source/fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module fetch_ctrl (
    input  logic             clk,
    input  logic             rst_n,
    input  fetch_pkg::xlen_t pc,
    input  logic             flush,         // redirect strobe.
    output logic             step,          // advance the pc generator.
    output logic             icache_read,
    output imem_pkg::addr_t  icache_addr,
    input  logic             icache_resp,   // one-cycle pulse with the read data.
    input  imem_pkg::word_t  icache_rdata,
    fetch_queue_if.producer  enq
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;
    fetch_pkg::xlen_t        buf_pc;         // pc of the held word, or the stale address in DROP.
    fetch_pkg::inst_t        buf_inst;
    logic                    capture;        // latch a good response into the buffer.
    logic                    park;           // keep the outstanding address across a redirect.

    always_comb begin
        state_next = state;
        capture    = 1'b0;
        park       = 1'b0;
        case (state)
            fetch_pkg::IDLE: begin
                state_next = fetch_pkg::REQ_WAIT;  // pc already holds any redirect target.
            end
            fetch_pkg::REQ_WAIT: begin
                if (icache_resp) begin
                    if (flush) begin
                        state_next = fetch_pkg::IDLE;  // response belongs to the old path.
                    end else begin
                        state_next = fetch_pkg::HOLD;
                        capture    = 1'b1;
                    end
                end else if (flush) begin
                    state_next = fetch_pkg::DROP;
                    park       = 1'b1;
                end
            end
            fetch_pkg::HOLD: begin
                if (flush || enq.ready) begin
                    state_next = fetch_pkg::IDLE;
                end
            end
            fetch_pkg::DROP: begin
                if (icache_resp) begin
                    state_next = fetch_pkg::IDLE;  // the stale word is simply not captured.
                end
            end
            default: begin
                state_next = fetch_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= fetch_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (capture || park) begin
            buf_pc <= pc;
        end
        if (capture) begin
            buf_inst <= icache_rdata;
        end
    end

    // the read is withdrawn in the cycle its response arrives.
    assign icache_read = ((state == fetch_pkg::REQ_WAIT) || (state == fetch_pkg::DROP))
                         && !icache_resp;

    // the pc has moved on during DROP, so the parked address is shown instead.
    assign icache_addr = (state == fetch_pkg::DROP) ? buf_pc : pc;

    assign enq.valid = (state == fetch_pkg::HOLD);
    assign enq.pc    = buf_pc;
    assign enq.inst  = buf_inst;

    assign step = enq.valid && enq.ready;  // a redirect load overrides this in pc_gen.

endmodule

`default_nettype wire

//--- source/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;  // width of a pc value.
    localparam int ILEN = 32;  // width of one instruction word.

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;

    // one instruction per fetch, so the pc advances by a single word.
    localparam xlen_t INST_BYTES = 32'd4;

    // fetch controller states.
    // IDLE issues a read on the next cycle, REQ_WAIT waits for the cache,
    // HOLD offers the captured word to the queue, DROP waits out a stale read.
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        REQ_WAIT = 2'd1,
        HOLD     = 2'd2,
        DROP     = 2'd3
    } fetch_state_e;

endpackage

`default_nettype wire

//--- source/fetch_queue_if.sv
`timescale 1ns/1ps
`default_nettype none

// carries one fetched pc and instruction pair from the controller to the queue.
interface fetch_queue_if;

    logic             valid;  // payload is held steady until taken or flushed.
    logic             ready;  // queue has room for one more entry.
    fetch_pkg::xlen_t pc;
    fetch_pkg::inst_t inst;

    modport producer (
        output valid,
        output pc,
        output inst,
        input  ready
    );

    modport consumer (
        input  valid,
        input  pc,
        input  inst,
        output ready
    );

endinterface

`default_nettype wire

//--- source/frontend_top.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter fetch_pkg::xlen_t RESET_VECTOR = 32'h1eceb000,
    parameter int               QUEUE_DEPTH  = 16
) (
    input  logic             clk,
    input  logic             rst_n,

    output logic             icache_read,
    output imem_pkg::addr_t  icache_addr,
    input  logic             icache_resp,
    input  imem_pkg::word_t  icache_rdata,

    input  logic             redirect,
    input  fetch_pkg::xlen_t redirect_pc,

    output logic             inst_valid,
    output fetch_pkg::xlen_t inst_pc,
    output fetch_pkg::inst_t inst_data,
    input  logic             inst_deq
);

    fetch_pkg::xlen_t pc;
    logic             step;

    fetch_queue_if fq_if ();  // fetch controller to instruction queue.

    pc_gen #(
        .RESET_VECTOR (RESET_VECTOR)
    ) u_pc_gen (
        .clk     (clk),
        .rst_n   (rst_n),
        .step    (step),
        .load    (redirect),
        .load_pc (redirect_pc),
        .pc      (pc)
    );

    fetch_ctrl u_fetch_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .flush        (redirect),  // a redirect also cancels the fetch in progress.
        .step         (step),
        .icache_read  (icache_read),
        .icache_addr  (icache_addr),
        .icache_resp  (icache_resp),
        .icache_rdata (icache_rdata),
        .enq          (fq_if.producer)
    );

    instr_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_instr_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .flush      (redirect),
        .enq        (fq_if.consumer),
        .deq        (inst_deq),
        .head_valid (inst_valid),
        .head_pc    (inst_pc),
        .head_inst  (inst_data)
    );

endmodule

`default_nettype wire

//--- source/imem_pkg.sv
`default_nettype none

package imem_pkg;

    localparam int ADDR_WIDTH = 32;  // byte address on the cache port.
    localparam int DATA_WIDTH = 32;  // one read returns one word.

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [DATA_WIDTH-1:0] word_t;

endpackage

`default_nettype wire

//--- source/instr_queue.sv
`timescale 1ns/1ps
`default_nettype none

module instr_queue #(
    parameter int QUEUE_DEPTH = 16
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             flush,       // drop every entry, including one arriving now.
    fetch_queue_if.consumer  enq,
    input  logic             deq,         // pop the head, ignored when empty.
    output logic             head_valid,
    output fetch_pkg::xlen_t head_pc,
    output fetch_pkg::inst_t head_inst
);

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_pkg::xlen_t pc_mem   [QUEUE_DEPTH];
    fetch_pkg::inst_t inst_mem [QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign enq.ready  = (count != CNT_W'(QUEUE_DEPTH));
    assign head_valid = (count != '0);

    assign push = enq.valid && enq.ready && !flush;
    assign pop  = deq && head_valid && !flush;

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= enq.pc;
            inst_mem[wr_ptr] <= enq.inst;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // both or neither leave the level unchanged.
            endcase
        end
    end

    // head is read straight from storage, so a new entry shows one cycle after it lands.
    assign head_pc   = pc_mem[rd_ptr];
    assign head_inst = inst_mem[rd_ptr];

endmodule

`default_nettype wire

//--- source/pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

module pc_gen #(
    parameter fetch_pkg::xlen_t RESET_VECTOR = 32'h1eceb000
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             step,     // the current pc was handed to the queue.
    input  logic             load,     // redirect to load_pc.
    input  fetch_pkg::xlen_t load_pc,
    output fetch_pkg::xlen_t pc
);

    fetch_pkg::xlen_t pc_next;

    // a redirect wins over a step in the same cycle, since the stepped
    // instruction belongs to the path being thrown away.
    always_comb begin
        pc_next = pc;
        if (load) begin
            pc_next = load_pc;
        end else if (step) begin
            pc_next = pc + fetch_pkg::INST_BYTES;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_VECTOR;
        end else begin
            pc <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- verif/frontend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module frontend_tb;

    localparam fetch_pkg::xlen_t RESET_VECTOR = 32'h1eceb000;
    localparam int QUEUE_DEPTH = 16;

    localparam int RESET_LEN   = 20;
    localparam int SEQ_LEN     = 400;
    localparam int STALL_LEN   = 200;
    localparam int DRAIN_LEN   = 100;
    localparam int REDIR_LEN   = 1000;
    localparam int MIX_LEN     = 3000;
    localparam int CYCLE_LIMIT = (RESET_LEN + SEQ_LEN + STALL_LEN + DRAIN_LEN + REDIR_LEN
                                  + MIX_LEN) * 8;

    logic             clk;
    logic             rst_n;
    logic             icache_read;
    imem_pkg::addr_t  icache_addr;
    logic             icache_resp;
    imem_pkg::word_t  icache_rdata;
    logic             redirect;
    fetch_pkg::xlen_t redirect_pc;
    logic             inst_valid;
    fetch_pkg::xlen_t inst_pc;
    fetch_pkg::inst_t inst_data;
    logic             inst_deq;
    logic [2:0]       latency;
    int               protocol_errors;

    logic [31:0]      rng_state;
    fetch_pkg::xlen_t exp_pc;       // reference pc of the next instruction to leave the queue.
    int               checks;
    int               errors;
    int               deq_total;
    int               redir_total;
    int               cycle_count;
    int               test_checks0;
    int               test_errors0;
    string            current_test;

    logic             s_valid;      // DUT outputs sampled 1 ns after the edge.
    fetch_pkg::xlen_t s_pc;
    fetch_pkg::inst_t s_data;
    logic             s_read;
    imem_pkg::addr_t  s_addr;

    tb_clkgen #(
        .PERIOD_NS    (20),
        .RESET_CYCLES (10)
    ) u_clkgen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    imem_model u_imem (
        .clk             (clk),
        .latency         (latency),
        .icache_read     (icache_read),
        .icache_addr     (icache_addr),
        .icache_resp     (icache_resp),
        .icache_rdata    (icache_rdata),
        .protocol_errors (protocol_errors)
    );

    frontend_top #(
        .RESET_VECTOR (RESET_VECTOR),
        .QUEUE_DEPTH  (QUEUE_DEPTH)
    ) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .icache_read  (icache_read),
        .icache_addr  (icache_addr),
        .icache_resp  (icache_resp),
        .icache_rdata (icache_rdata),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .inst_valid   (inst_valid),
        .inst_pc      (inst_pc),
        .inst_data    (inst_data),
        .inst_deq     (inst_deq)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_random();
        return int'(r % n);
    endfunction

    // the cache holds each address rotated left by 7 bits and xored with a constant.
    function automatic fetch_pkg::inst_t mem_word(input fetch_pkg::xlen_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a5a5a;
    endfunction

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        checks = checks + 1;
        if (expected !== actual) begin
            errors = errors + 1;
            $display("Fail %s %s: expected 0x%08h, actual 0x%08h",
                     current_test, name, expected, actual);
        end
    endtask

    task automatic start_test(input string name);
        current_test = name;
        test_checks0 = checks;
        test_errors0 = errors;
    endtask

    task automatic finish_test();
        $display("test %s finished: %0d checks, %0d errors", current_test,
                 checks - test_checks0, errors - test_errors0);
    endtask

    // each call samples the outputs of one cycle, then drives inputs and updates the model.
    // redir_mode is 0 for none, 1 for a forced redirect and 2 for a random one.
    task automatic drive_cycle(input int deq_pct, input int redir_mode);
        logic             do_deq;
        logic             do_redir;
        fetch_pkg::xlen_t target;
        @(posedge clk);
        #1;
        s_valid = inst_valid;
        s_pc    = inst_pc;
        s_data  = inst_data;
        s_read  = icache_read;
        s_addr  = icache_addr;
        #1;
        do_deq      = (rand_below(100) < deq_pct);
        do_redir    = (redir_mode == 1) || ((redir_mode == 2) && (rand_below(50) == 0));
        target      = next_random() & 32'hffff_fffc;
        inst_deq    = do_deq;
        redirect    = do_redir;
        redirect_pc = target;
        latency     = 3'(1 + rand_below(6));
        if (do_deq && s_valid && !do_redir) begin  // a redirect suppresses the pop.
            compare_values("deq_pc", exp_pc, s_pc);
            compare_values("deq_data", mem_word(exp_pc), s_data);
            exp_pc    = exp_pc + 32'd4;
            deq_total = deq_total + 1;
        end
        if (do_redir) begin
            exp_pc      = target;
            redir_total = redir_total + 1;
        end
    endtask

    task automatic check_reset();
        logic released;
        start_test("reset");
        released = 1'b0;
        while (!released) begin
            @(posedge clk);
            #1;
            if (rst_n) begin
                released = 1'b1;
                compare_values("first_read", 1, icache_read);
                compare_values("first_addr", RESET_VECTOR, icache_addr);
                compare_values("valid_after_reset", 0, inst_valid);
            end else begin
                compare_values("read_in_reset", 0, icache_read);
                compare_values("valid_in_reset", 0, inst_valid);
            end
        end
        finish_test();
    endtask

    task automatic fetch_in_order();
        int deq_before;
        start_test("sequential");
        deq_before = deq_total;
        repeat (SEQ_LEN) drive_cycle(100, 0);
        compare_values("some_dequeued", 1, (deq_total - deq_before) > 0);
        finish_test();
    endtask

    task automatic fill_and_drain();
        int i;
        int read_late;
        int deq_before;
        start_test("backpressure");
        read_late = 0;
        for (i = 0; i < STALL_LEN; i++) begin
            drive_cycle(0, 0);
            if ((i >= STALL_LEN - 50) && s_read) begin
                read_late = read_late + 1;
            end
        end
        compare_values("read_idle_when_full", 0, read_late);
        compare_values("head_valid", 1, s_valid);
        // the held word sits at the pc, so the distance from the head is the fill level.
        compare_values("stored_count", QUEUE_DEPTH, (s_addr - exp_pc) >> 2);
        deq_before = deq_total;
        repeat (QUEUE_DEPTH) drive_cycle(100, 0);
        compare_values("drain_count", QUEUE_DEPTH, deq_total - deq_before);
        repeat (DRAIN_LEN - QUEUE_DEPTH) drive_cycle(100, 0);
        finish_test();
    endtask

    task automatic redirect_sweep();
        int i;
        int wait_cycles;
        int deq_before;
        start_test("redirect");
        for (i = 0; i < 20; i++) begin
            wait_cycles = 5 + rand_below(20);
            repeat (wait_cycles) drive_cycle(60, 0);
            if (i % 2 == 1) begin
                while (!s_read) drive_cycle(60, 0);  // aim at a read in flight.
            end
            drive_cycle(60, 1);
            deq_before = deq_total;
            while (deq_total == deq_before) drive_cycle(100, 0);
        end
        finish_test();
    endtask

    task automatic random_mix();
        start_test("random_mix");
        repeat (MIX_LEN) drive_cycle(60, 2);
        compare_values("cache_protocol", 0, protocol_errors);
        finish_test();
    endtask

    // free-running cycle counter that ends a run which has stalled.
    initial begin
        cycle_count = 0;
        while (cycle_count <= CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        inst_deq    = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        latency     = 3'd1;
        rng_state   = 32'd3;
        exp_pc      = RESET_VECTOR;
        checks      = 0;
        errors      = 0;
        deq_total   = 0;
        redir_total = 0;
        check_reset();
        fetch_in_order();
        fill_and_drain();
        redirect_sweep();
        random_mix();
        $display("summary: %0d checks, %0d errors, %0d dequeues, %0d redirects",
                 checks, errors, deq_total, redir_total);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/imem_model.sv
`timescale 1ns/1ps
`default_nettype none

// behavioral instruction cache that answers one read at a time.
module imem_model (
    input  logic            clk,
    input  logic [2:0]      latency,          // cycles from the first read cycle to the response.
    input  logic            icache_read,
    input  imem_pkg::addr_t icache_addr,
    output logic            icache_resp,
    output imem_pkg::word_t icache_rdata,
    output int              protocol_errors   // read dropped or address moved while pending.
);

    logic            busy;
    imem_pkg::addr_t req_addr;
    int              remaining;
    logic [2:0]      lat_q;
    logic            read_s;
    imem_pkg::addr_t addr_s;

    // contents are the address rotated left by 7 bits and xored with a constant.
    function automatic imem_pkg::word_t word_at(input imem_pkg::addr_t a);
        return {a[24:0], a[31:25]} ^ 32'h5a5a5a5a;
    endfunction

    initial begin
        icache_resp     = 1'b0;
        icache_rdata    = '0;
        busy            = 1'b0;
        req_addr        = '0;
        remaining       = 0;
        protocol_errors = 0;
    end

    always begin
        @(posedge clk);
        lat_q = latency;  // the testbench changes it only after the edge.
        #1;
        read_s = icache_read;
        addr_s = icache_addr;
        if (busy && !icache_resp) begin
            if (!read_s || (addr_s != req_addr)) begin
                protocol_errors = protocol_errors + 1;
            end
        end
        #1;
        if (icache_resp) begin
            icache_resp = 1'b0;  // the pulse lasts one cycle.
            busy        = 1'b0;
        end else if (busy) begin
            remaining = remaining - 1;
            if (remaining == 0) begin
                icache_resp  = 1'b1;
                icache_rdata = word_at(req_addr);
            end
        end else if (read_s) begin
            busy      = 1'b1;
            req_addr  = addr_s;
            remaining = (lat_q == 3'd0) ? 1 : int'(lat_q);
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD_NS      = 20,
    parameter int RESET_CYCLES   = 10,
    parameter int DRIVE_DELAY_NS = 2
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #(DRIVE_DELAY_NS);
        rst_n = 1'b1;  // released just after an edge, like every other input.
    end

endmodule

`default_nettype wire

//--- vlog.f
source/fetch_pkg.sv
source/imem_pkg.sv
source/fetch_queue_if.sv
source/pc_gen.sv
source/fetch_ctrl.sv
source/instr_queue.sv
source/frontend_top.sv
verif/tb_clkgen.sv
verif/imem_model.sv
verif/frontend_tb.sv
